//--- common/burst_rw_defines.svh
// Word width, burst length width, counter idle code and arbiter state encodings
`ifndef BURST_RW_DEFINES_SVH
`define BURST_RW_DEFINES_SVH

// One width serves both addresses and data words
`define BURST_RW_ADDR_WIDTH 32
`define BURST_RW_LEN_WIDTH  8

// Burst counter code for no burst in progress
`define BURST_RW_CNT_IDLE {`BURST_RW_LEN_WIDTH{1'b1}}

// Arbiter state encodings
`define BURST_RW_STATE_WIDTH 3
`define BURST_RW_ST_IDLE     3'd0
`define BURST_RW_ST_R_NLAST  3'd1
`define BURST_RW_ST_R_LAST   3'd2
`define BURST_RW_ST_W_NLAST  3'd3
`define BURST_RW_ST_W_LAST   3'd4

`endif

//--- common/burst_rw_pkg.sv
// Shared word, length and arbiter state types for the burst read/write pipeline
`default_nettype none

`include "burst_rw_defines.svh"

package burst_rw_pkg;

    typedef logic [`BURST_RW_ADDR_WIDTH-1:0] addr_t; // Address or data word
    typedef logic [`BURST_RW_LEN_WIDTH-1:0]  len_t;  // Burst length minus one

    // Owner of the shared middle stage
    typedef enum logic [`BURST_RW_STATE_WIDTH-1:0] {
        arb_idle    = `BURST_RW_ST_IDLE,    // Nobody owns T2
        arb_r_nlast = `BURST_RW_ST_R_NLAST, // Read burst, more beats
        arb_r_last  = `BURST_RW_ST_R_LAST,  // Read burst, final beat
        arb_w_nlast = `BURST_RW_ST_W_NLAST, // Write burst, more beats
        arb_w_last  = `BURST_RW_ST_W_LAST   // Write burst, final beat
    } arb_state_t;

endpackage

`default_nettype wire

//--- rtl/rw_arbiter.sv
// Read/write arbiter FSM with stage advance, grant and upstream ready logic
`default_nettype none

module rw_arbiter (
    input  logic clk,
    input  logic rst_n,
    input  logic d_r_ready,
    input  logic d_w_ready,
    input  logic r_t0_valid,      // Read T0 holds a beat
    input  logic r_t0_last,       // Read T0 beat ends its burst
    input  logic r_t0_free,       // Read counter idle or on last beat
    input  logic w_t0_addr_valid, // Write T0 address side full
    input  logic w_t0_data_valid, // Write T0 data side full
    input  logic w_t0_last,
    input  logic w_t0_free,
    output logic r_advance,
    output logic w_advance,
    output logic r_grant,
    output logic w_grant,
    output logic u_r_ready,
    output logic u_w_addr_ready,
    output logic u_w_data_ready
);

    burst_rw_pkg::arb_state_t state;
    burst_rw_pkg::arb_state_t state_next;
    burst_rw_pkg::arb_state_t pick;   // Choice when the stage is up for grabs
    logic                     r_beat;
    logic                     w_beat;
    logic                     r_open; // Next state lets read stages move
    logic                     w_open;
    logic                     a_merge_ok;
    logic                     d_merge_ok;

    assign r_beat = d_r_ready && r_t0_valid;
    assign w_beat = d_w_ready && w_t0_addr_valid && w_t0_data_valid; // Merged pair ready

    // Read wins a tie
    always_comb begin
        if (r_beat) begin
            pick = r_t0_last ? burst_rw_pkg::arb_r_last : burst_rw_pkg::arb_r_nlast;
        end else if (w_beat) begin
            pick = w_t0_last ? burst_rw_pkg::arb_w_last : burst_rw_pkg::arb_w_nlast;
        end else begin
            pick = burst_rw_pkg::arb_idle; // Nothing waiting
        end
    end

    always_comb begin
        state_next = state; // Hold on stall
        case (state)
            burst_rw_pkg::arb_r_nlast: begin
                if (d_r_ready) begin // Stay with the read burst
                    state_next = r_t0_last ? burst_rw_pkg::arb_r_last : burst_rw_pkg::arb_r_nlast;
                end
            end
            burst_rw_pkg::arb_w_nlast: begin
                if (d_w_ready) begin // Stay with the write burst
                    state_next = w_t0_last ? burst_rw_pkg::arb_w_last : burst_rw_pkg::arb_w_nlast;
                end
            end
            burst_rw_pkg::arb_r_last: begin
                if (d_r_ready) begin
                    state_next = pick;
                end
            end
            burst_rw_pkg::arb_w_last: begin
                if (d_w_ready) begin
                    state_next = pick;
                end
            end
            default: state_next = pick; // Idle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= burst_rw_pkg::arb_idle;
        end else begin
            state <= state_next;
        end
    end

    // Current state opens T2 of its own path
    assign r_grant = (state == burst_rw_pkg::arb_r_nlast) || (state == burst_rw_pkg::arb_r_last);
    assign w_grant = (state == burst_rw_pkg::arb_w_nlast) || (state == burst_rw_pkg::arb_w_last);

    // Next state decides which T0/T1 moves
    assign r_open = (state_next == burst_rw_pkg::arb_idle)
                 || (state_next == burst_rw_pkg::arb_r_nlast)
                 || (state_next == burst_rw_pkg::arb_r_last);
    assign w_open = (state_next == burst_rw_pkg::arb_idle)
                 || (state_next == burst_rw_pkg::arb_w_nlast)
                 || (state_next == burst_rw_pkg::arb_w_last);

    assign r_advance = d_r_ready && r_open;
    assign w_advance = d_w_ready && w_open;

    // Each side loads when both empty, both full, or only the other is full
    assign a_merge_ok = w_t0_data_valid || !w_t0_addr_valid;
    assign d_merge_ok = w_t0_addr_valid || !w_t0_data_valid;

    assign u_r_ready      = r_t0_free && r_advance;
    assign u_w_addr_ready = w_t0_free && a_merge_ok && w_advance;
    assign u_w_data_ready = d_merge_ok && w_advance;

endmodule

`default_nettype wire

//--- read/read_burst_gen.sv
// Read burst counter and address generator for stage T0
`default_nettype none

`include "burst_rw_defines.svh"

module read_burst_gen (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 r_advance,  // Read T0/T1 may move
    input  logic                 u_r_valid,
    input  burst_rw_pkg::addr_t  u_r_addr,
    input  burst_rw_pkg::len_t   u_r_length, // Beats minus one
    output burst_rw_pkg::addr_t  t0_addr,
    output logic                 t0_valid,
    output logic                 t0_last,
    output logic                 t0_free
);

    burst_rw_pkg::len_t cnt; // Beats left after this one

    assign t0_valid = (cnt != `BURST_RW_CNT_IDLE);
    assign t0_last  = (cnt == '0);
    assign t0_free  = !t0_valid || t0_last; // Can take a new burst

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= `BURST_RW_CNT_IDLE;
            t0_addr <= '0;
        end else if (r_advance) begin
            if (t0_free) begin
                // Start next burst or go idle
                cnt     <= u_r_valid ? u_r_length : `BURST_RW_CNT_IDLE;
                t0_addr <= u_r_addr;
            end else begin
                cnt     <= cnt - burst_rw_pkg::len_t'(1);      // Count down
                t0_addr <= t0_addr + burst_rw_pkg::addr_t'(1); // Next address
            end
        end
    end

endmodule

`default_nettype wire

//--- read/read_pipe.sv
// Read stages T1 and T2 with memory stand-in and last flag
`default_nettype none

module read_pipe (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 r_advance,
    input  logic                 r_grant,   // Arbiter in a read state
    input  logic                 d_r_ready,
    input  logic                 t0_valid,
    input  logic                 t0_last,
    input  burst_rw_pkg::addr_t  t0_addr,
    output burst_rw_pkg::addr_t  d_r_data,
    output logic                 d_r_valid,
    output logic                 d_r_last
);

    burst_rw_pkg::addr_t t1_addr;
    logic                t1_valid;
    logic                t1_last;

    // T1 follows T0 when the read side moves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t1_addr  <= '0;
            t1_valid <= 1'b0;
            t1_last  <= 1'b0;
        end else if (r_advance) begin
            t1_addr  <= t0_addr;
            t1_valid <= t0_valid;
            t1_last  <= t0_last;
        end
    end

    // T2 frozen while downstream stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_r_data  <= '0;
            d_r_valid <= 1'b0;
            d_r_last  <= 1'b0;
        end else if (d_r_ready) begin
            if (r_grant) begin
                d_r_valid <= t1_valid;
                d_r_last  <= t1_valid && t1_last;
                if (t1_valid) begin
                    d_r_data <= t1_addr; // Memory returns its own address
                end
            end else begin
                d_r_valid <= 1'b0; // Stage owned by writes
                d_r_last  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- write/write_burst_gen.sv
// Write address counter, data capture register and address/data merge for stage T0
`default_nettype none

`include "burst_rw_defines.svh"

module write_burst_gen (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 w_advance,      // Write T0/T1 may move
    input  logic                 u_w_addr_valid,
    input  logic                 u_w_data_valid,
    input  burst_rw_pkg::addr_t  u_w_addr,
    input  burst_rw_pkg::len_t   u_w_length,     // Beats minus one
    input  burst_rw_pkg::addr_t  u_w_data,
    output burst_rw_pkg::addr_t  t0_addr,
    output burst_rw_pkg::addr_t  t0_data,
    output logic                 t0_addr_valid,
    output logic                 t0_data_valid,
    output logic                 t0_last,
    output logic                 t0_free
);

    burst_rw_pkg::len_t cnt;       // Address beats left after this one
    logic               addr_load; // Address side steps
    logic               data_load; // Data side captures

    assign t0_addr_valid = (cnt != `BURST_RW_CNT_IDLE);
    assign t0_last       = (cnt == '0);
    assign t0_free       = !t0_addr_valid || t0_last;

    // A full side waits until the other side fills, so pairs stay one to one
    assign addr_load = w_advance && (t0_data_valid || !t0_addr_valid);
    assign data_load = w_advance && (t0_addr_valid || !t0_data_valid);

    // Address counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= `BURST_RW_CNT_IDLE;
            t0_addr <= '0;
        end else if (addr_load) begin
            if (t0_free) begin
                cnt     <= u_w_addr_valid ? u_w_length : `BURST_RW_CNT_IDLE;
                t0_addr <= u_w_addr;
            end else begin
                cnt     <= cnt - burst_rw_pkg::len_t'(1);
                t0_addr <= t0_addr + burst_rw_pkg::addr_t'(1); // Next beat address
            end
        end
    end

    // Data capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t0_data       <= '0;
            t0_data_valid <= 1'b0;
        end else if (data_load) begin
            t0_data       <= u_w_data;
            t0_data_valid <= u_w_data_valid; // Empty again if no word offered
        end
    end

endmodule

`default_nettype wire

//--- write/write_pipe.sv
// Write stages T1, T2 and T3 with response and address/data mismatch flag
`default_nettype none

module write_pipe (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 w_advance,
    input  logic                 w_grant,       // Arbiter in a write state
    input  logic                 d_w_ready,
    input  logic                 t0_addr_valid,
    input  logic                 t0_data_valid,
    input  burst_rw_pkg::addr_t  t0_addr,
    input  burst_rw_pkg::addr_t  t0_data,
    output burst_rw_pkg::addr_t  d_w_response,
    output logic                 d_w_valid,
    output logic                 d_w_error
);

    burst_rw_pkg::addr_t t1_addr;
    burst_rw_pkg::addr_t t1_data;
    logic                t1_valid;
    burst_rw_pkg::addr_t t2_addr;
    burst_rw_pkg::addr_t t2_data;
    logic                t2_valid;

    // T1 takes the merged pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t1_addr  <= '0;
            t1_data  <= '0;
            t1_valid <= 1'b0;
        end else if (w_advance) begin
            t1_addr  <= t0_addr;
            t1_data  <= t0_data;
            t1_valid <= t0_addr_valid && t0_data_valid; // Beat only when both sides full
        end
    end

    // T2 open only while writes own the stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t2_addr  <= '0;
            t2_data  <= '0;
            t2_valid <= 1'b0;
        end else if (d_w_ready) begin
            if (w_grant) begin
                t2_addr  <= t1_addr;
                t2_data  <= t1_data;
                t2_valid <= t1_valid;
            end else begin
                t2_valid <= 1'b0;
            end
        end
    end

    // T3 response carries the address, error flags a data mismatch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_w_response <= '0;
            d_w_valid    <= 1'b0;
            d_w_error    <= 1'b0;
        end else if (d_w_ready) begin
            d_w_valid <= t2_valid;
            d_w_error <= t2_valid && (t2_data != t2_addr);
            if (t2_valid) begin
                d_w_response <= t2_addr;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/burst_rw_pipeline.sv
// Top level of the burst read/write pipeline, arbiter and both datapaths
`default_nettype none

module burst_rw_pipeline (
    input  logic                 clk,
    input  logic                 rst_n,
    // Read requests
    input  burst_rw_pkg::addr_t  u_r_addr,
    input  burst_rw_pkg::len_t   u_r_length,
    input  logic                 u_r_valid,
    output logic                 u_r_ready,
    // Write address requests
    input  burst_rw_pkg::addr_t  u_w_addr,
    input  burst_rw_pkg::len_t   u_w_length,
    input  logic                 u_w_addr_valid,
    output logic                 u_w_addr_ready,
    // Write data words
    input  burst_rw_pkg::addr_t  u_w_data,
    input  logic                 u_w_data_valid,
    output logic                 u_w_data_ready,
    // Read data
    output burst_rw_pkg::addr_t  d_r_data,
    output logic                 d_r_valid,
    output logic                 d_r_last,
    input  logic                 d_r_ready,
    // Write responses
    output burst_rw_pkg::addr_t  d_w_response,
    output logic                 d_w_valid,
    output logic                 d_w_error,
    input  logic                 d_w_ready
);

    logic                r_advance;
    logic                w_advance;
    logic                r_grant;
    logic                w_grant;
    burst_rw_pkg::addr_t r_t0_addr;
    logic                r_t0_valid;
    logic                r_t0_last;
    logic                r_t0_free;
    burst_rw_pkg::addr_t w_t0_addr;
    burst_rw_pkg::addr_t w_t0_data;
    logic                w_t0_addr_valid;
    logic                w_t0_data_valid;
    logic                w_t0_last;
    logic                w_t0_free;

    rw_arbiter rw_arbiter_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .d_r_ready       (d_r_ready),
        .d_w_ready       (d_w_ready),
        .r_t0_valid      (r_t0_valid),
        .r_t0_last       (r_t0_last),
        .r_t0_free       (r_t0_free),
        .w_t0_addr_valid (w_t0_addr_valid),
        .w_t0_data_valid (w_t0_data_valid),
        .w_t0_last       (w_t0_last),
        .w_t0_free       (w_t0_free),
        .r_advance       (r_advance),
        .w_advance       (w_advance),
        .r_grant         (r_grant),
        .w_grant         (w_grant),
        .u_r_ready       (u_r_ready),
        .u_w_addr_ready  (u_w_addr_ready),
        .u_w_data_ready  (u_w_data_ready)
    );

    read_burst_gen read_burst_gen_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .r_advance  (r_advance),
        .u_r_valid  (u_r_valid),
        .u_r_addr   (u_r_addr),
        .u_r_length (u_r_length),
        .t0_addr    (r_t0_addr),
        .t0_valid   (r_t0_valid),
        .t0_last    (r_t0_last),
        .t0_free    (r_t0_free)
    );

    read_pipe read_pipe_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .r_advance (r_advance),
        .r_grant   (r_grant),
        .d_r_ready (d_r_ready),
        .t0_valid  (r_t0_valid),
        .t0_last   (r_t0_last),
        .t0_addr   (r_t0_addr),
        .d_r_data  (d_r_data),
        .d_r_valid (d_r_valid),
        .d_r_last  (d_r_last)
    );

    write_burst_gen write_burst_gen_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .w_advance      (w_advance),
        .u_w_addr_valid (u_w_addr_valid),
        .u_w_data_valid (u_w_data_valid),
        .u_w_addr       (u_w_addr),
        .u_w_length     (u_w_length),
        .u_w_data       (u_w_data),
        .t0_addr        (w_t0_addr),
        .t0_data        (w_t0_data),
        .t0_addr_valid  (w_t0_addr_valid),
        .t0_data_valid  (w_t0_data_valid),
        .t0_last        (w_t0_last),
        .t0_free        (w_t0_free)
    );

    write_pipe write_pipe_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .w_advance     (w_advance),
        .w_grant       (w_grant),
        .d_w_ready     (d_w_ready),
        .t0_addr_valid (w_t0_addr_valid),
        .t0_data_valid (w_t0_data_valid),
        .t0_addr       (w_t0_addr),
        .t0_data       (w_t0_data),
        .d_w_response  (d_w_response),
        .d_w_valid     (d_w_valid),
        .d_w_error     (d_w_error)
    );

endmodule

`default_nettype wire

//--- test/burst_rw_tb.sv
// Testbench for the burst read/write pipeline with stimulus, reference model, scoreboard and timeout
`default_nettype none

module burst_rw_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAND_BURSTS = 12; // Random bursts per path

    logic                clk;
    logic                rst_n;
    burst_rw_pkg::addr_t u_r_addr;
    burst_rw_pkg::len_t  u_r_length;
    logic                u_r_valid;
    logic                u_r_ready;
    burst_rw_pkg::addr_t u_w_addr;
    burst_rw_pkg::len_t  u_w_length;
    logic                u_w_addr_valid;
    logic                u_w_addr_ready;
    burst_rw_pkg::addr_t u_w_data;
    logic                u_w_data_valid;
    logic                u_w_data_ready;
    burst_rw_pkg::addr_t d_r_data;
    logic                d_r_valid;
    logic                d_r_last;
    logic                d_r_ready;
    burst_rw_pkg::addr_t d_w_response;
    logic                d_w_valid;
    logic                d_w_error;
    logic                d_w_ready;

    burst_rw_pkg::addr_t rd_addr_q[$];  // Read requests not yet sent
    burst_rw_pkg::len_t  rd_len_q[$];
    burst_rw_pkg::addr_t wr_addr_q[$];  // Write address requests not yet sent
    burst_rw_pkg::len_t  wr_len_q[$];
    burst_rw_pkg::addr_t wr_word_q[$];  // Write data stream
    burst_rw_pkg::addr_t exp_r_data[$]; // Read beats still owed
    logic                exp_r_last[$];
    burst_rw_pkg::addr_t exp_w_addr[$]; // Write responses still owed
    logic                exp_w_err[$];

    int read_errors  = 0;
    int write_errors = 0;
    int other_errors = 0;
    int r_seen       = 0; // Read beats delivered
    int w_seen       = 0;
    int cycle_count  = 0;
    int cycle_limit  = 0;
    bit random_ready = 1'b0; // Downstream readies toggle randomly

    burst_rw_pipeline burst_rw_pipeline_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .u_r_addr       (u_r_addr),
        .u_r_length     (u_r_length),
        .u_r_valid      (u_r_valid),
        .u_r_ready      (u_r_ready),
        .u_w_addr       (u_w_addr),
        .u_w_length     (u_w_length),
        .u_w_addr_valid (u_w_addr_valid),
        .u_w_addr_ready (u_w_addr_ready),
        .u_w_data       (u_w_data),
        .u_w_data_valid (u_w_data_valid),
        .u_w_data_ready (u_w_data_ready),
        .d_r_data       (d_r_data),
        .d_r_valid      (d_r_valid),
        .d_r_last       (d_r_last),
        .d_r_ready      (d_r_ready),
        .d_w_response   (d_w_response),
        .d_w_valid      (d_w_valid),
        .d_w_error      (d_w_error),
        .d_w_ready      (d_w_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    // Beat address wraps at the word width
    function automatic burst_rw_pkg::addr_t beat_addr(input burst_rw_pkg::addr_t start,
                                                      input int idx);
        return start + burst_rw_pkg::addr_t'(idx);
    endfunction

    function automatic logic data_mismatch(input burst_rw_pkg::addr_t data,
                                           input burst_rw_pkg::addr_t addr);
        return data != addr;
    endfunction

    function automatic void add_read(input burst_rw_pkg::addr_t start,
                                     input burst_rw_pkg::len_t len);
        rd_addr_q.push_back(start);
        rd_len_q.push_back(len);
        for (int i = 0; i <= int'(len); i++) begin
            exp_r_data.push_back(beat_addr(start, i));
            exp_r_last.push_back(i == int'(len)); // Final beat only
        end
    endfunction

    // bad_beat below zero means every word matches its address
    function automatic void add_write(input burst_rw_pkg::addr_t start,
                                      input burst_rw_pkg::len_t len, input int bad_beat);
        burst_rw_pkg::addr_t a;
        burst_rw_pkg::addr_t d;
        wr_addr_q.push_back(start);
        wr_len_q.push_back(len);
        for (int i = 0; i <= int'(len); i++) begin
            a = beat_addr(start, i);
            d = (i == bad_beat) ? ~a : a;
            wr_word_q.push_back(d);
            exp_w_addr.push_back(a);
            exp_w_err.push_back(data_mismatch(d, a));
        end
    endfunction

    function automatic void expect_low(input string name, input logic value);
        if (value !== 1'b0) begin
            $display("** Error: %s = %h, expected 0", name, value);
            other_errors++;
        end
    endfunction

    function automatic void print_counts();
        $display("Errors: read %0d, write %0d, other %0d", read_errors, write_errors, other_errors);
    endfunction

    task automatic send_reads(input int count);
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            u_r_addr   = rd_addr_q.pop_front();
            u_r_length = rd_len_q.pop_front();
            u_r_valid  = 1'b1;
            do @(posedge clk); while (!u_r_ready); // Held until accepted
        end
        @(negedge clk);
        u_r_valid = 1'b0;
    endtask

    task automatic send_write_addrs(input int count);
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            u_w_addr       = wr_addr_q.pop_front();
            u_w_length     = wr_len_q.pop_front();
            u_w_addr_valid = 1'b1;
            do @(posedge clk); while (!u_w_addr_ready);
        end
        @(negedge clk);
        u_w_addr_valid = 1'b0;
    endtask

    task automatic send_write_data(input int count);
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            u_w_data       = wr_word_q.pop_front();
            u_w_data_valid = 1'b1;
            do @(posedge clk); while (!u_w_data_ready);
        end
        @(negedge clk);
        u_w_data_valid = 1'b0;
    endtask

    task automatic wait_beats(input int r_target, input int w_target);
        while (r_seen < r_target || w_seen < w_target) begin
            @(posedge clk);
        end
    endtask

    // Random downstream readies while enabled
    task automatic toggle_readies();
        forever begin
            @(negedge clk);
            if (random_ready) begin
                d_r_ready = ($urandom_range(0, 3) != 0); // Ready about three cycles in four
                d_w_ready = ($urandom_range(0, 3) != 0);
            end
        end
    endtask

    // Scoreboard samples the outputs at the edge that transfers them
    always @(posedge clk) begin : compare
        burst_rw_pkg::addr_t want_word;
        logic                want_bit;
        if (rst_n && d_r_valid && d_r_ready) begin
            if (exp_r_data.size() == 0) begin
                $display("Read beat with data %h arrived when no read beat was owed", d_r_data);
                other_errors++;
            end else begin
                want_word = exp_r_data.pop_front();
                want_bit  = exp_r_last.pop_front();
                if (d_r_data !== want_word) begin
                    $display("** Error: d_r_data = %h, expected %h", d_r_data, want_word);
                    read_errors++;
                end
                if (d_r_last !== want_bit) begin
                    $display("** Error: d_r_last = %h, expected %h", d_r_last, want_bit);
                    read_errors++;
                end
                r_seen++;
            end
        end
        if (rst_n && d_w_valid && d_w_ready) begin
            if (exp_w_addr.size() == 0) begin
                $display("Write response %h arrived when no response was owed", d_w_response);
                other_errors++;
            end else begin
                want_word = exp_w_addr.pop_front();
                want_bit  = exp_w_err.pop_front();
                if (d_w_response !== want_word) begin
                    $display("** Error: d_w_response = %h, expected %h", d_w_response, want_word);
                    write_errors++;
                end
                if (d_w_error !== want_bit) begin
                    $display("** Error: d_w_error = %h, expected %h", d_w_error, want_bit);
                    write_errors++;
                end
                w_seen++;
            end
        end
    end

    initial begin : watchdog
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, %0d read and %0d write beats never arrived",
                 cycle_count, exp_r_data.size(), exp_w_addr.size());
        print_counts();
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        int                  r_target;
        int                  w_target;
        int                  words;
        int                  len;
        int                  bad;
        burst_rw_pkg::addr_t addr;
        void'($urandom(32'h76e0));
        fork
            toggle_readies(); // Runs for the whole test
        join_none
        rst_n          = 1'b0;
        u_r_addr       = '0;
        u_r_length     = '0;
        u_r_valid      = 1'b0;
        u_w_addr       = '0;
        u_w_length     = '0;
        u_w_addr_valid = 1'b0;
        u_w_data       = '0;
        u_w_data_valid = 1'b0;
        d_r_ready      = 1'b0;
        d_w_ready      = 1'b0;
        add_read(32'hffff_fffe, 8'd3);      // Wraps through zero
        add_write(32'h0000_0200, 8'd3, -1);
        add_write(32'h0000_0300, 8'd1, 1);  // Second word corrupted
        r_target = exp_r_data.size();
        w_target = exp_w_addr.size();
        for (int n = 0; n < RAND_BURSTS; n++) begin
            addr = $urandom;
            len  = $urandom_range(0, 7);
            add_read(addr, burst_rw_pkg::len_t'(len));
            addr = $urandom;
            len  = $urandom_range(0, 7);
            bad  = ($urandom_range(0, 3) == 0) ? int'($urandom_range(0, len)) : -1;
            add_write(addr, burst_rw_pkg::len_t'(len), bad);
        end
        cycle_limit = (exp_r_data.size() + exp_w_addr.size()) * 20;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        expect_low("d_r_valid", d_r_valid);
        expect_low("d_r_last", d_r_last);
        expect_low("d_w_valid", d_w_valid);
        expect_low("d_w_error", d_w_error);
        d_r_ready = 1'b1;
        d_w_ready = 1'b1;
        fork
            send_reads(1);
            send_write_addrs(2);
            send_write_data(w_target); // One word per beat
        join
        wait_beats(r_target, w_target);
        random_ready = 1'b1;
        words        = wr_word_q.size();
        fork
            send_reads(RAND_BURSTS);
            send_write_addrs(RAND_BURSTS);
            send_write_data(words);
        join
        wait_beats(r_seen + exp_r_data.size(), w_seen + exp_w_addr.size());
        random_ready = 1'b0;
        @(negedge clk);
        d_r_ready = 1'b1;
        d_w_ready = 1'b1;
        repeat (20) @(posedge clk); // Catch any extra beats
        print_counts();
        if (read_errors + write_errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/burst_rw_pkg.sv
rtl/rw_arbiter.sv
read/read_burst_gen.sv
read/read_pipe.sv
write/write_burst_gen.sv
write/write_pipe.sv
rtl/burst_rw_pipeline.sv
test/burst_rw_tb.sv

//--- Bender.yml
package:
  name: burst_rw_pipeline

sources:
  - include_dirs:
      - common
    files:
      - common/burst_rw_pkg.sv
      - rtl/rw_arbiter.sv
      - read/read_burst_gen.sv
      - read/read_pipe.sv
      - write/write_burst_gen.sv
      - write/write_pipe.sv
      - rtl/burst_rw_pipeline.sv
  - target: test
    files:
      - test/burst_rw_tb.sv
